// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = csr_tb
FILE_LIST = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Regression failed
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
src/csr_pkg.sv
src/csr_machine_regs.sv
src/csr_counters.sv
src/csr_access.sv
src/csr_unit.sv
verif/csr_sva.sv
verif/csr_tb.sv

// File: src/csr_access.sv
`timescale 1ns/1ps

module csr_access #(
    parameter logic [31:0] HART_ID = 32'h0
) (
    input  logic               stall,
    input  logic               read,
    input  logic               write,
    input  logic [1:0]         write_op,
    input  logic               src,
    input  logic [11:0]        csr_addr,
    input  logic [31:0]        rs1_value,
    input  logic [31:0]        imm_value,
    input  logic [31:0]        mstatus_word,
    input  logic [31:0]        mie_word,
    input  logic [31:0]        mtvec_word,
    input  logic [31:0]        mscratch_word,
    input  logic [31:0]        mepc_word,
    input  logic [31:0]        mcause_word,
    input  logic [31:0]        mtval_word,
    input  logic [31:0]        mip_word,
    input  logic [63:0]        cycle_count,
    input  logic [63:0]        instret_count,
    output logic [31:0]        read_value,
    output logic               illegal,
    output csr_pkg::csr_word_u new_value,
    output logic               we_mstatus,
    output logic               we_mie,
    output logic               we_mtvec,
    output logic               we_mscratch,
    output logic               we_mepc,
    output logic               we_mcause,
    output logic               we_mtval
);
    import csr_pkg::*;

    logic [31:0] csr_data;
    logic        known;
    logic        read_only;
    logic [31:0] source;
    logic        write_ok;

    always_comb begin
        known    = 1'b1;
        csr_data = '0;
        case (csr_addr) inside
            csr_mstatus:   csr_data = mstatus_word;
            csr_misa:      csr_data = misa_value;
            csr_mie:       csr_data = mie_word;
            csr_mtvec:     csr_data = mtvec_word;
            csr_mscratch:  csr_data = mscratch_word;
            csr_mepc:      csr_data = mepc_word;
            csr_mcause:    csr_data = mcause_word;
            csr_mtval:     csr_data = mtval_word;
            csr_mip:       csr_data = mip_word;
            csr_mcycle, csr_cycle, csr_time:
                csr_data = cycle_count[31:0];
            csr_mcycleh, csr_cycleh, csr_timeh:
                csr_data = cycle_count[63:32];
            csr_minstret, csr_instret:
                csr_data = instret_count[31:0];
            csr_minstreth, csr_instreth:
                csr_data = instret_count[63:32];
            csr_mhartid:   csr_data = HART_ID;
            csr_mvendorid, csr_marchid, csr_mimpid,
            [csr_mhpmevent_first:csr_mhpmevent_last],
            [csr_mhpmcounter_first:csr_mhpmcounter_last],
            [csr_mhpmcounterh_first:csr_mhpmcounterh_last],
            [csr_pmp_first:csr_pmp_last]:
                csr_data = '0;
            default:       known = 1'b0;
        endcase
    end

    // the machine counters have no write path, so their block is read-only too.
    assign read_only = (csr_addr[11:10] == 2'b11) || (csr_addr[11:8] == 4'hB);

    assign illegal    = ((read || write) && !known) || (write && read_only);
    assign read_value = (read || write) ? csr_data : '0;

    assign source = (src == src_reg) ? rs1_value : imm_value;

    always_comb begin
        case (write_op)
            write_op_rw: new_value.raw = source;
            write_op_rs: new_value.raw = csr_data | source;
            write_op_rc: new_value.raw = csr_data & ~source;
            default:     new_value.raw = csr_data;
        endcase
    end

    assign write_ok = write && !stall && known && !read_only;

    assign we_mstatus  = write_ok && (csr_addr == csr_mstatus);
    assign we_mie      = write_ok && (csr_addr == csr_mie);
    assign we_mtvec    = write_ok && (csr_addr == csr_mtvec);
    assign we_mscratch = write_ok && (csr_addr == csr_mscratch);
    assign we_mepc     = write_ok && (csr_addr == csr_mepc);
    assign we_mcause   = write_ok && (csr_addr == csr_mcause);
    assign we_mtval    = write_ok && (csr_addr == csr_mtval);

endmodule

// File: src/csr_counters.sv
`timescale 1ns/1ps

module csr_counters (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_retired,
    output logic [63:0] cycle_count,
    output logic [63:0] instret_count
);

    // the cycle counter runs on every edge and also serves the time alias.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 64'd1;
        end
    end

    // retirement comes from writeback, so a stalled front end does not hold it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instret_count <= '0;
        end else if (instr_retired) begin
            instret_count <= instret_count + 64'd1;
        end
    end

endmodule

// File: src/csr_machine_regs.sv
`timescale 1ns/1ps

module csr_machine_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  csr_pkg::csr_word_u new_value,
    input  logic              we_mstatus,
    input  logic              we_mie,
    input  logic              we_mtvec,
    input  logic              we_mscratch,
    input  logic              we_mepc,
    input  logic              we_mcause,
    input  logic              we_mtval,
    input  logic              irq_external,
    input  logic              irq_timer,
    input  logic              irq_software,
    output logic [31:0]       mstatus_word,
    output logic [31:0]       mie_word,
    output logic [31:0]       mtvec_word,
    output logic [31:0]       mscratch_word,
    output logic [31:0]       mepc_word,
    output logic [31:0]       mcause_word,
    output logic [31:0]       mtval_word,
    output logic [31:0]       mip_word,
    output logic              irq_request
);
    import csr_pkg::*;

    logic        mstatus_mpie;
    logic        mstatus_mie;
    logic        mie_meie;
    logic        mie_mtie;
    logic        mie_msie;
    logic [29:0] mtvec_base;
    logic        mtvec_mode;
    logic [31:0] mscratch;
    logic [29:0] mepc;
    logic        mcause_interrupt;
    logic [3:0]  mcause_code;
    logic [31:0] mtval;
    logic        mip_meip;
    logic        mip_mtip;
    logic        mip_msip;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mpie <= 1'b0;
            mstatus_mie  <= 1'b0;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_msie     <= 1'b0;
            mtvec_base   <= '0;
            mtvec_mode   <= 1'b0;
        end else begin
            if (we_mstatus) begin
                mstatus_mpie <= new_value.status_view.mpie;
                mstatus_mie  <= new_value.status_view.mie;
            end
            if (we_mie) begin
                mie_meie <= new_value.raw[11];
                mie_mtie <= new_value.raw[7];
                mie_msie <= new_value.raw[3];
            end
            if (we_mtvec) begin
                mtvec_base <= new_value.tvec_view.base;
                mtvec_mode <= new_value.tvec_view.mode;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch         <= '0;
            mepc             <= '0;
            mcause_interrupt <= 1'b0;
            mcause_code      <= '0;
            mtval            <= '0;
        end else begin
            if (we_mscratch)
                mscratch <= new_value.raw;
            if (we_mepc)
                mepc <= new_value.raw[31:2];
            if (we_mcause) begin
                mcause_interrupt <= new_value.raw[31];
                mcause_code      <= new_value.raw[3:0];
            end
            if (we_mtval)
                mtval <= new_value.raw;
        end
    end

    // the pending bits follow the interrupt lines one cycle late.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mip_meip <= 1'b0;
            mip_mtip <= 1'b0;
            mip_msip <= 1'b0;
        end else begin
            mip_meip <= irq_external;
            mip_mtip <= irq_timer;
            mip_msip <= irq_software;
        end
    end

    // mpp is hardwired to machine mode since no other privilege exists.
    assign mstatus_word  = {19'b0, 2'b11, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
    assign mie_word      = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
    assign mtvec_word    = {mtvec_base, 1'b0, mtvec_mode};
    assign mscratch_word = mscratch;
    assign mepc_word     = {mepc, 2'b00};
    assign mcause_word   = {mcause_interrupt, 27'b0, mcause_code};
    assign mtval_word    = mtval;
    assign mip_word      = {20'b0, mip_meip, 3'b0, mip_mtip, 3'b0, mip_msip, 3'b0};

    assign irq_request = mstatus_mie && ((mie_meie && mip_meip) ||
                                         (mie_mtie && mip_mtip) ||
                                         (mie_msie && mip_msip));

endmodule

// File: src/csr_pkg.sv
package csr_pkg;

    // machine trap setup and handling registers.
    localparam logic [11:0] csr_mstatus  = 12'h300;
    localparam logic [11:0] csr_misa     = 12'h301;
    localparam logic [11:0] csr_mie      = 12'h304;
    localparam logic [11:0] csr_mtvec    = 12'h305;
    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mepc     = 12'h341;
    localparam logic [11:0] csr_mcause   = 12'h342;
    localparam logic [11:0] csr_mtval    = 12'h343;
    localparam logic [11:0] csr_mip      = 12'h344;

    // machine counters and their user-level aliases.
    localparam logic [11:0] csr_mcycle    = 12'hB00;
    localparam logic [11:0] csr_minstret  = 12'hB02;
    localparam logic [11:0] csr_mcycleh   = 12'hB80;
    localparam logic [11:0] csr_minstreth = 12'hB82;
    localparam logic [11:0] csr_cycle     = 12'hC00;
    localparam logic [11:0] csr_time      = 12'hC01;
    localparam logic [11:0] csr_instret   = 12'hC02;
    localparam logic [11:0] csr_cycleh    = 12'hC80;
    localparam logic [11:0] csr_timeh     = 12'hC81;
    localparam logic [11:0] csr_instreth  = 12'hC82;

    // machine information registers.
    localparam logic [11:0] csr_mvendorid = 12'hF11;
    localparam logic [11:0] csr_marchid   = 12'hF12;
    localparam logic [11:0] csr_mimpid    = 12'hF13;
    localparam logic [11:0] csr_mhartid   = 12'hF14;

    // these ranges are decoded as present but always read zero.
    localparam logic [11:0] csr_mhpmevent_first    = 12'h323;
    localparam logic [11:0] csr_mhpmevent_last     = 12'h33F;
    localparam logic [11:0] csr_mhpmcounter_first  = 12'hB03;
    localparam logic [11:0] csr_mhpmcounter_last   = 12'hB1F;
    localparam logic [11:0] csr_mhpmcounterh_first = 12'hB83;
    localparam logic [11:0] csr_mhpmcounterh_last  = 12'hB9F;
    localparam logic [11:0] csr_pmp_first          = 12'h3A0;
    localparam logic [11:0] csr_pmp_last           = 12'h3BF;

    localparam logic [1:0] write_op_rw = 2'b00;
    localparam logic [1:0] write_op_rs = 2'b01;
    localparam logic [1:0] write_op_rc = 2'b10;

    localparam logic src_imm = 1'b0;
    localparam logic src_reg = 1'b1;

    // mxl is 1 for RV32 and only the I extension bit is set.
    localparam logic [31:0] misa_value = 32'h4000_0100;

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [23:0] reserved_hi;
            logic        mpie;
            logic [2:0]  reserved_mid;
            logic        mie;
            logic [2:0]  reserved_lo;
        } status_view;
        struct packed {
            logic [29:0] base;
            logic        reserved;
            logic        mode;
        } tvec_view;
    } csr_word_u;

endpackage

// File: src/csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
    parameter logic [31:0] HART_ID = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        read,
    input  logic        write,
    input  logic [1:0]  write_op,
    input  logic        src,
    input  logic        instr_retired,
    input  logic [11:0] csr_addr,
    input  logic [31:0] rs1_value,
    input  logic [31:0] imm_value,
    input  logic        irq_external,
    input  logic        irq_timer,
    input  logic        irq_software,
    output logic [31:0] read_value,
    output logic        illegal,
    output logic        irq_request,
    output logic [31:0] trap_vector
);
    import csr_pkg::*;

    csr_word_u   new_value;
    logic        we_mstatus;
    logic        we_mie;
    logic        we_mtvec;
    logic        we_mscratch;
    logic        we_mepc;
    logic        we_mcause;
    logic        we_mtval;
    logic [31:0] mstatus_word;
    logic [31:0] mie_word;
    logic [31:0] mscratch_word;
    logic [31:0] mepc_word;
    logic [31:0] mcause_word;
    logic [31:0] mtval_word;
    logic [31:0] mip_word;
    logic [63:0] cycle_count;
    logic [63:0] instret_count;

    // the fetch stage takes the mtvec word directly as its trap vector.
    csr_machine_regs u_machine_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .new_value     (new_value),
        .we_mstatus    (we_mstatus),
        .we_mie        (we_mie),
        .we_mtvec      (we_mtvec),
        .we_mscratch   (we_mscratch),
        .we_mepc       (we_mepc),
        .we_mcause     (we_mcause),
        .we_mtval      (we_mtval),
        .irq_external  (irq_external),
        .irq_timer     (irq_timer),
        .irq_software  (irq_software),
        .mstatus_word  (mstatus_word),
        .mie_word      (mie_word),
        .mtvec_word    (trap_vector),
        .mscratch_word (mscratch_word),
        .mepc_word     (mepc_word),
        .mcause_word   (mcause_word),
        .mtval_word    (mtval_word),
        .mip_word      (mip_word),
        .irq_request   (irq_request)
    );

    csr_counters u_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_retired (instr_retired),
        .cycle_count   (cycle_count),
        .instret_count (instret_count)
    );

    csr_access #(
        .HART_ID (HART_ID)
    ) u_access (
        .stall         (stall),
        .read          (read),
        .write         (write),
        .write_op      (write_op),
        .src           (src),
        .csr_addr      (csr_addr),
        .rs1_value     (rs1_value),
        .imm_value     (imm_value),
        .mstatus_word  (mstatus_word),
        .mie_word      (mie_word),
        .mtvec_word    (trap_vector),
        .mscratch_word (mscratch_word),
        .mepc_word     (mepc_word),
        .mcause_word   (mcause_word),
        .mtval_word    (mtval_word),
        .mip_word      (mip_word),
        .cycle_count   (cycle_count),
        .instret_count (instret_count),
        .read_value    (read_value),
        .illegal       (illegal),
        .new_value     (new_value),
        .we_mstatus    (we_mstatus),
        .we_mie        (we_mie),
        .we_mtvec      (we_mtvec),
        .we_mscratch   (we_mscratch),
        .we_mepc       (we_mepc),
        .we_mcause     (we_mcause),
        .we_mtval      (we_mtval)
    );

endmodule

// File: verif/csr_sva.sv
`timescale 1ns/1ps

module csr_checks (
    input logic        clk,
    input logic        rst_n,
    input logic        read,
    input logic        write,
    input logic [11:0] csr_addr,
    input logic [31:0] read_value,
    input logic        illegal,
    input logic        irq_request
);

    logic counter_addr;

    // the counter blocks move on their own every cycle.
    assign counter_addr = (csr_addr[11:8] == 4'hB) || (csr_addr[11:8] == 4'hC);

    property illegal_leaves_value;
        @(posedge clk) disable iff (!rst_n)
            (illegal && !counter_addr) |=>
                (!read || (csr_addr != $past(csr_addr)) || (read_value == $past(read_value)));
    endproperty

    property unknown_reads_zero;
        @(posedge clk) disable iff (!rst_n)
            (illegal && read && !write) |-> (read_value == 32'h0);
    endproperty

    property irq_quiet_after_reset;
        @(posedge clk) $rose(rst_n) |-> !irq_request;
    endproperty

    assert property (illegal_leaves_value)
        else $error("an illegal access changed the next read of the same address");
    assert property (unknown_reads_zero)
        else $error("an unknown address returned a non-zero read value");
    assert property (irq_quiet_after_reset)
        else $error("irq_request was active in the first cycle after reset");

endmodule

bind csr_unit csr_checks u_checks (
    .clk         (clk),
    .rst_n       (rst_n),
    .read        (read),
    .write       (write),
    .csr_addr    (csr_addr),
    .read_value  (read_value),
    .illegal     (illegal),
    .irq_request (irq_request)
);

// File: verif/csr_tb.sv
`timescale 1ns/1ps

module csr_tb;
    import csr_pkg::*;

    localparam logic [31:0] hart_id      = 32'h0000_0003;
    localparam logic [11:0] unknown_addr = 12'h7C0;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        read;
    logic        write;
    logic [1:0]  write_op;
    logic        src;
    logic        instr_retired;
    logic [11:0] csr_addr;
    logic [31:0] rs1_value;
    logic [31:0] imm_value;
    logic        irq_external;
    logic        irq_timer;
    logic        irq_software;
    logic [31:0] read_value;
    logic        illegal;
    logic        irq_request;
    logic [31:0] trap_vector;

    logic [31:0] lfsr_state = 32'h6ee8_bb11;
    int          edge_count = 0;
    int          error_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;

    csr_unit #(.HART_ID(hart_id)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // rising edges since reset release, which is what mcycle must show.
    always @(posedge clk) begin
        if (rst_n)
            edge_count <= edge_count + 1;
    end

    // right-shifting galois LFSR, one step for every bit handed out.
    function automatic logic [31:0] random_word();
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < 32; i++) begin
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hD000_0001 : 32'h0);
            value = {lfsr_state[0], value[31:1]};
        end
        return value;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else begin
            $display("[FAIL] %0t %s: read %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        test_count++;
        if (error_count == start) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - start);
        end
    endtask

    task automatic read_csr(input logic [11:0] addr, output logic [31:0] value,
                            output logic ill);
        @(posedge clk);
        #2;
        read = 1'b1;
        write = 1'b0;
        csr_addr = addr;
        @(negedge clk);
        value = read_value;
        ill = illegal;
    endtask

    task automatic expect_read(input logic [11:0] addr, input logic [31:0] expected,
                               input string what);
        logic [31:0] value;
        logic        ill;
        read_csr(addr, value, ill);
        check_value(what, value, expected);
        check_value({what, " illegal flag"}, {31'b0, ill}, 32'h0);
    endtask

    // the write commits on the edge after the drive, then the strobe drops.
    task automatic write_csr(input logic [11:0] addr, input logic [1:0] op,
                             input logic use_reg, input logic [31:0] data,
                             input logic hold, output logic ill);
        @(posedge clk);
        #2;
        read = 1'b0;
        write = 1'b1;
        write_op = op;
        csr_addr = addr;
        stall = hold;
        src = use_reg ? src_reg : src_imm;
        rs1_value = use_reg ? data : ~data;
        imm_value = use_reg ? ~data : data;
        @(negedge clk);
        ill = illegal;
        @(posedge clk);
        #2;
        write = 1'b0;
        stall = 1'b0;
    endtask

    initial begin
        logic [31:0] value;
        logic [31:0] first;
        logic [31:0] model;
        logic [31:0] data;
        logic [1:0]  op;
        logic        ill;
        int          start;
        int          i;

        {rst_n, stall, read, write, write_op, src, instr_retired} = '0;
        {irq_external, irq_timer, irq_software} = '0;
        csr_addr = '0;
        rs1_value = '0;
        imm_value = '0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        start = error_count;
        expect_read(csr_mstatus, 32'h0000_1800, "mstatus reset");
        expect_read(csr_mie, 32'h0, "mie reset");
        expect_read(csr_mtvec, 32'h0, "mtvec reset");
        expect_read(csr_mscratch, 32'h0, "mscratch reset");
        expect_read(csr_mepc, 32'h0, "mepc reset");
        expect_read(csr_mcause, 32'h0, "mcause reset");
        expect_read(csr_mtval, 32'h0, "mtval reset");
        expect_read(csr_mip, 32'h0, "mip reset");
        expect_read(csr_misa, misa_value, "misa");
        expect_read(csr_mhartid, hart_id, "mhartid");
        expect_read(csr_mhpmevent_first, 32'h0, "mhpmevent3");
        check_value("irq_request reset", {31'b0, irq_request}, 32'h0);
        report_test("reset and constants", start);

        start = error_count;
        model = '0;
        for (i = 0; i < 6; i++) begin
            data = random_word();
            op = (i % 3 == 0) ? write_op_rw : (i % 3 == 1) ? write_op_rs : write_op_rc;
            model = (op == write_op_rw) ? data :
                    (op == write_op_rs) ? (model | data) : (model & ~data);
            write_csr(csr_mscratch, op, (i % 2 == 1), data, 1'b0, ill);
            check_value("mscratch write illegal flag", {31'b0, ill}, 32'h0);
            expect_read(csr_mscratch, model, "mscratch after write");
        end
        write_csr(csr_mscratch, write_op_rw, 1'b1, random_word(), 1'b1, ill);
        expect_read(csr_mscratch, model, "mscratch after stalled write");
        report_test("write ops", start);

        start = error_count;
        write_csr(csr_mstatus, write_op_rw, 1'b1, '1, 1'b0, ill);
        expect_read(csr_mstatus, 32'h0000_1888, "mstatus masked");
        write_csr(csr_mtvec, write_op_rs, 1'b0, '1, 1'b0, ill);
        expect_read(csr_mtvec, 32'hFFFF_FFFD, "mtvec masked");
        check_value("trap_vector", trap_vector, 32'hFFFF_FFFD);
        write_csr(csr_mepc, write_op_rw, 1'b0, '1, 1'b0, ill);
        expect_read(csr_mepc, 32'hFFFF_FFFC, "mepc masked");
        write_csr(csr_mcause, write_op_rw, 1'b1, '1, 1'b0, ill);
        expect_read(csr_mcause, 32'h8000_000F, "mcause masked");
        write_csr(csr_mstatus, write_op_rc, 1'b1, '1, 1'b0, ill);
        expect_read(csr_mstatus, 32'h0000_1800, "mstatus cleared");
        report_test("field masking", start);

        start = error_count;
        read_csr(csr_mcycle, value, ill);
        check_value("mcycle", value, edge_count);
        read_csr(csr_mcycle, value, ill);
        check_value("mcycle one cycle later", value, edge_count);
        read_csr(csr_cycle, value, ill);
        check_value("cycle alias", value, edge_count);
        read_csr(csr_time, value, ill);
        check_value("time alias", value, edge_count);
        read_csr(csr_minstret, first, ill);
        check_value("minstret before retirements", first, 32'h0);
        // a stall must not hold back retirement counting.
        @(posedge clk);
        #2;
        instr_retired = 1'b1;
        stall = 1'b1;
        repeat (7) @(posedge clk);
        #2;
        instr_retired = 1'b0;
        stall = 1'b0;
        read_csr(csr_minstret, value, ill);
        check_value("minstret after 7 retirements", value, 32'd7);
        report_test("counters", start);

        start = error_count;
        read_csr(unknown_addr, value, ill);
        check_value("unknown address value", value, 32'h0);
        check_value("unknown address illegal flag", {31'b0, ill}, 32'h1);
        read_csr(unknown_addr, value, ill);
        write_csr(csr_mcycle, write_op_rw, 1'b1, random_word(), 1'b0, ill);
        check_value("mcycle write illegal flag", {31'b0, ill}, 32'h1);
        read_csr(csr_mcycle, value, ill);
        check_value("mcycle after illegal write", value, edge_count);
        write_csr(csr_mvendorid, write_op_rs, 1'b0, '1, 1'b0, ill);
        check_value("mvendorid write illegal flag", {31'b0, ill}, 32'h1);
        expect_read(csr_mvendorid, 32'h0, "mvendorid after illegal write");
        report_test("illegal accesses", start);

        start = error_count;
        write_csr(csr_mie, write_op_rs, 1'b1, 32'h0000_0080, 1'b0, ill);
        write_csr(csr_mstatus, write_op_rs, 1'b0, 32'h0000_0008, 1'b0, ill);
        expect_read(csr_mip, 32'h0, "mip before interrupt");
        check_value("irq_request idle", {31'b0, irq_request}, 32'h0);
        @(posedge clk);
        #2;
        irq_timer = 1'b1;
        expect_read(csr_mip, 32'h0000_0080, "mip after irq_timer");
        i = 0;
        while (irq_request !== 1'b1 && i < 20) begin
            @(negedge clk);
            i++;
        end
        if (irq_request !== 1'b1) begin
            $display("timeout: irq_request never rose after irq_timer was raised");
            error_count++;
        end
        write_csr(csr_mstatus, write_op_rc, 1'b1, 32'h0000_0008, 1'b0, ill);
        @(negedge clk);
        check_value("irq_request after clearing mstatus.mie", {31'b0, irq_request}, 32'h0);
        report_test("interrupts", start);

        $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
